// File: design/adpll_cfg_pkg.sv
package adpll_cfg_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Word widths
   ///////////////////////////////////////////////////////////////////////

   // FCW split into integer and fractional parts
   localparam int FCWW = 26;
   localparam int INTW = 12;
   localparam int FRAW = 14;

   // One guard bit over the FCW for the signed phase error
   localparam int ACCW = 27;
   localparam int OTWW = 13;

   // Signed capacitor bank words
   localparam int LW  = 5;
   localparam int MSW = 8;

   ///////////////////////////////////////////////////////////////////////
   // Bank limits and loop gain
   ///////////////////////////////////////////////////////////////////////

   localparam int L_MAX  = 12;
   localparam int L_MIN  = -13;
   localparam int MS_MAX = 127;
   localparam int MS_MIN = -128;
   localparam int OTW_SHIFT = 7;

   // Power-up marks, counted from entry into ST_PU
   localparam int TCW       = 9;
   localparam int T_TDC_PU  = 16;
   localparam int T_INJ_PU  = 48;
   localparam int T_PU_DONE = 112;
   localparam int T_CH_LOCK = 480;

   // Lock detector repeat counts
   localparam int LCW           = 5;
   localparam int LOCK_N_FINE   = 15;
   localparam int LOCK_N_COARSE = 8;

endpackage

// File: design/adpll_types_pkg.sv
package adpll_types_pkg;

   typedef enum logic [1:0] {
      MODE_PD   = 2'd0,
      MODE_TEST = 2'd1,
      MODE_RX   = 2'd2,
      MODE_TX   = 2'd3
   } adpll_mode_e;

   // Acquisition runs large, medium then small bank
   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,
      ST_PU   = 3'd1,
      ST_CL   = 3'd2,
      ST_CM   = 3'd3,
      ST_CS   = 3'd4
   } acq_state_e;

   typedef struct packed {
      logic [3:0] alpha;
      logic [3:0] beta;
      logic [2:0] lambda;
      logic [1:0] iir_n;
      logic       en_integral;
   } filt_cfg_s;

   // Per-mode small bank coefficients
   typedef struct packed {
      logic [3:0] alpha_s;
      logic [2:0] lambda;
      logic [1:0] iir_n;
   } coef_set_s;

   typedef struct packed {
      logic [3:0] alpha_l;
      logic [3:0] alpha_m;
      logic [3:0] beta;
      coef_set_s  rx;
      coef_set_s  tx;
   } coef_regs_s;

   typedef struct packed {
      logic signed [adpll_cfg_pkg::LW-1:0]  l;
      logic signed [adpll_cfg_pkg::MSW-1:0] m;
      logic signed [adpll_cfg_pkg::MSW-1:0] s;
   } bank_words_s;

   typedef struct packed {
      logic dco_pd;
      logic tdc_pd;
      logic tdc_pd_inj;
   } pwr_ctrl_s;

   typedef struct packed {
      bank_words_s words;
      pwr_ctrl_s   pd;
   } test_ctrl_s;

endpackage

// File: design/loop_filter.sv
module loop_filter (
   input  logic                                     clk,
   input  logic                                     rst_accum_all,
   input  logic                                     accum_clr,
   input  logic [adpll_cfg_pkg::FCWW-1:0]           fcw,
   input  logic [adpll_cfg_pkg::INTW-1:0]           tdc_word,
   input  adpll_types_pkg::filt_cfg_s               filt,
   output logic signed [adpll_cfg_pkg::OTWW-1:0]    otw_round
);

   logic                                   clr;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  ph_diff;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  acc_d, acc_q;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  iir1_d, iir2_d, iir3_d;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  iir1_q, iir2_q, iir3_q;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  tap;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  integ_d, integ_q;
   logic signed [adpll_cfg_pkg::ACCW-1:0]  ntw, otw;
   logic signed [adpll_cfg_pkg::OTWW-1:0]  otw_int;

   // First-order IIR step with gain 2^-lambda
   function automatic logic signed [adpll_cfg_pkg::ACCW-1:0] iir_step(
      input logic signed [adpll_cfg_pkg::ACCW-1:0] x,
      input logic signed [adpll_cfg_pkg::ACCW-1:0] y,
      input logic [2:0]                            lam
   );
      return (x >>> lam) - (y >>> lam) + y;
   endfunction

   assign clr = rst_accum_all | accum_clr;

   // Phase error against the TDC integer word
   assign ph_diff = $signed({1'b0, fcw}) -
                    $signed({1'b0, tdc_word, {adpll_cfg_pkg::FRAW{1'b0}}});
   assign acc_d   = acc_q + ph_diff;

   assign iir1_d = iir_step(acc_d,  iir1_q, filt.lambda);
   assign iir2_d = iir_step(iir1_d, iir2_q, filt.lambda);
   assign iir3_d = iir_step(iir2_d, iir3_q, filt.lambda);

   always_comb begin
      case (filt.iir_n)
         2'd0:    tap = acc_d;
         2'd1:    tap = iir1_d;
         2'd2:    tap = iir2_d;
         default: tap = iir3_d;
      endcase
   end

   assign integ_d = tap + integ_q;

   always_ff @(posedge clk) begin
      if (clr) begin
         acc_q   <= '0;
         iir1_q  <= '0;
         iir2_q  <= '0;
         iir3_q  <= '0;
         integ_q <= '0;
      end else begin
         acc_q  <= acc_d;
         iir1_q <= iir1_d;
         iir2_q <= iir2_d;
         iir3_q <= iir3_d;
         if (filt.en_integral) begin
            integ_q <= integ_d;
         end
      end
   end

   // Proportional path plus optional integral path
   assign ntw = filt.en_integral ? (integ_d >>> filt.beta) + (tap >>> filt.alpha)
                                 : (tap >>> filt.alpha);
   assign otw     = ntw <<< adpll_cfg_pkg::OTW_SHIFT;
   assign otw_int = otw[adpll_cfg_pkg::ACCW-1:adpll_cfg_pkg::FRAW];

   // Round half up on the top fractional bit
   assign otw_round = otw_int + $signed({{(adpll_cfg_pkg::OTWW-1){1'b0}},
                                         otw[adpll_cfg_pkg::FRAW-1]});

endmodule

// File: design/acq_sequencer.sv
module acq_sequencer (
   input  logic                                     clk,
   input  logic                                     rst_accum_all,
   input  logic [adpll_cfg_pkg::FCWW-1:0]           fcw,
   input  adpll_types_pkg::adpll_mode_e             mode,
   input  adpll_types_pkg::coef_regs_s              coefs,
   input  logic                                     lock_seen,
   input  logic signed [adpll_cfg_pkg::OTWW-1:0]    lock_word,
   output adpll_types_pkg::acq_state_e              state,
   output adpll_types_pkg::filt_cfg_s               filt,
   output logic                                     accum_clr,
   output logic                                     ld_en,
   output logic                                     ld_clr,
   output adpll_types_pkg::bank_words_s             fixed_words,
   output adpll_types_pkg::pwr_ctrl_s               pwr,
   output logic                                     channel_lock
);

   logic [adpll_cfg_pkg::FCWW-1:0]  fcw_last;
   adpll_types_pkg::adpll_mode_e    mode_last;
   logic [adpll_cfg_pkg::TCW-1:0]   time_cnt;
   logic                            en_integral;
   adpll_types_pkg::coef_set_s      cs;

   // Small bank coefficients follow the radio direction
   assign cs = (mode == adpll_types_pkg::MODE_TX) ? coefs.tx : coefs.rx;

   always_comb begin
      filt.alpha       = coefs.rx.alpha_s;
      filt.beta        = coefs.beta;
      filt.lambda      = coefs.rx.lambda;
      filt.iir_n       = 2'd0;
      filt.en_integral = en_integral;
      case (state)
         adpll_types_pkg::ST_CL: filt.alpha = coefs.alpha_l;
         adpll_types_pkg::ST_CM: filt.alpha = coefs.alpha_m;
         adpll_types_pkg::ST_CS: begin
            filt.alpha  = cs.alpha_s;
            filt.lambda = cs.lambda;
            filt.iir_n  = cs.iir_n;
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Acquisition FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         state        <= adpll_types_pkg::ST_IDLE;
         time_cnt     <= '0;
         pwr          <= '1;
         accum_clr    <= 1'b0;
         ld_en        <= 1'b0;
         ld_clr       <= 1'b0;
         fixed_words  <= '0;
         channel_lock <= 1'b0;
         en_integral  <= 1'b0;
         fcw_last     <= '0;
         mode_last    <= adpll_types_pkg::MODE_PD;
      end else begin
         fcw_last  <= fcw;
         mode_last <= mode;
         // Any FCW or mode change restarts acquisition
         if (fcw != fcw_last || mode != mode_last) begin
            state <= adpll_types_pkg::ST_IDLE;
         end else begin
            case (state)
               adpll_types_pkg::ST_IDLE: begin
                  time_cnt     <= '0;
                  fixed_words  <= '0;
                  ld_en        <= 1'b0;
                  ld_clr       <= 1'b1;
                  channel_lock <= 1'b0;
                  en_integral  <= 1'b0;
                  if (mode == adpll_types_pkg::MODE_PD) begin
                     pwr <= '1;
                  end
                  if (mode == adpll_types_pkg::MODE_RX || mode == adpll_types_pkg::MODE_TX) begin
                     state <= adpll_types_pkg::ST_PU;
                  end
               end
               adpll_types_pkg::ST_PU: begin
                  time_cnt   <= time_cnt + 1'b1;
                  pwr.dco_pd <= 1'b0;
                  if (time_cnt == adpll_cfg_pkg::T_TDC_PU) begin
                     pwr.tdc_pd <= 1'b0;
                  end
                  if (time_cnt == adpll_cfg_pkg::T_INJ_PU) begin
                     pwr.tdc_pd_inj <= 1'b0;
                  end
                  if (time_cnt == adpll_cfg_pkg::T_PU_DONE) begin
                     state     <= adpll_types_pkg::ST_CL;
                     accum_clr <= 1'b1;
                     time_cnt  <= '0;
                  end
               end
               adpll_types_pkg::ST_CL: begin
                  accum_clr <= 1'b0;
                  ld_clr    <= 1'b0;
                  ld_en     <= 1'b1;
                  if (lock_seen && !ld_clr) begin
                     fixed_words.l <= lock_word[adpll_cfg_pkg::LW-1:0];
                     state         <= adpll_types_pkg::ST_CM;
                     accum_clr     <= 1'b1;
                     ld_clr        <= 1'b1;
                  end
               end
               adpll_types_pkg::ST_CM: begin
                  accum_clr <= 1'b0;
                  ld_clr    <= 1'b0;
                  if (lock_seen && !ld_clr) begin
                     fixed_words.m <= lock_word[adpll_cfg_pkg::MSW-1:0];
                     state         <= adpll_types_pkg::ST_CS;
                     accum_clr     <= 1'b1;
                     ld_en         <= 1'b0;
                  end
               end
               adpll_types_pkg::ST_CS: begin
                  accum_clr <= 1'b0;
                  time_cnt  <= time_cnt + 1'b1;
                  if (coefs.beta != 4'd0) begin
                     en_integral <= 1'b1;
                  end
                  if (time_cnt == adpll_cfg_pkg::T_CH_LOCK) begin
                     channel_lock <= 1'b1;
                  end
               end
               default: state <= adpll_types_pkg::ST_IDLE;
            endcase
         end
      end
   end

endmodule

// File: design/freq_lock_detector.sv
module freq_lock_detector (
   input  logic                                     clk,
   input  logic                                     rst_accum_all,
   input  logic                                     ld_en,
   input  logic                                     ld_clr,
   input  adpll_types_pkg::acq_state_e              state,
   input  logic signed [adpll_cfg_pkg::OTWW-1:0]    otw_sat,
   output logic                                     lock_seen,
   output logic signed [adpll_cfg_pkg::OTWW-1:0]    lock_word
);

   logic signed [adpll_cfg_pkg::OTWW-1:0]  cand1, cand2;
   logic [adpll_cfg_pkg::LCW-1:0]          cnt1, cnt2;
   logic [adpll_cfg_pkg::LCW-1:0]          inc1, inc2;
   int                                     lock_n;

   assign inc1 = cnt1 + 1'b1;
   assign inc2 = cnt2 + 1'b1;

   // Coarse bank settles with fewer repeats
   assign lock_n = (state == adpll_types_pkg::ST_CL) ? adpll_cfg_pkg::LOCK_N_COARSE
                                                     : adpll_cfg_pkg::LOCK_N_FINE;

   always_ff @(posedge clk) begin
      if (rst_accum_all || ld_clr) begin
         cand1     <= '1;
         cand2     <= '1;
         cnt1      <= '0;
         cnt2      <= '0;
         lock_seen <= 1'b0;
         lock_word <= '1;
      end else if (ld_en) begin
         if (otw_sat == cand1) begin
            cnt1 <= inc1;
            if (inc1 == lock_n) begin
               lock_seen <= 1'b1;
               lock_word <= cand1;
            end
         end else if (otw_sat == cand2) begin
            cnt2 <= inc2;
            if (inc2 == lock_n) begin
               lock_seen <= 1'b1;
               lock_word <= cand2;
            end
         end else begin
            // New value pushes out the older candidate
            cand1 <= otw_sat;
            cnt1  <= 1;
            cand2 <= cand1;
            cnt2  <= cnt1;
         end
      end
   end

endmodule

// File: design/bank_word_combiner.sv
module bank_word_combiner (
   input  adpll_types_pkg::acq_state_e              state,
   input  adpll_types_pkg::adpll_mode_e             mode,
   input  logic                                     accum_clr,
   input  logic signed [adpll_cfg_pkg::OTWW-1:0]    otw_round,
   input  adpll_types_pkg::bank_words_s             fixed_words,
   input  adpll_types_pkg::test_ctrl_s              test,
   output logic signed [adpll_cfg_pkg::OTWW-1:0]    otw_sat,
   output adpll_types_pkg::bank_words_s             dco_words,
   output logic                                     channel_sat
);

   function automatic logic signed [adpll_cfg_pkg::OTWW-1:0] clamp(
      input logic signed [adpll_cfg_pkg::OTWW-1:0] v,
      input int                                    hi,
      input int                                    lo
   );
      if (v > hi) begin
         return hi[adpll_cfg_pkg::OTWW-1:0];
      end
      if (v < lo) begin
         return lo[adpll_cfg_pkg::OTWW-1:0];
      end
      return v;
   endfunction

   // Large bank has a narrower range
   assign otw_sat = (state == adpll_types_pkg::ST_CL) ?
                    clamp(otw_round, adpll_cfg_pkg::L_MAX, adpll_cfg_pkg::L_MIN) :
                    clamp(otw_round, adpll_cfg_pkg::MS_MAX, adpll_cfg_pkg::MS_MIN);

   always_comb begin
      if (mode == adpll_types_pkg::MODE_TEST) begin
         dco_words = test.words;
      end else begin
         dco_words.l = (state == adpll_types_pkg::ST_CL && !accum_clr) ?
                       otw_sat[adpll_cfg_pkg::LW-1:0] : fixed_words.l;
         dco_words.m = (state == adpll_types_pkg::ST_CM && !accum_clr) ?
                       otw_sat[adpll_cfg_pkg::MSW-1:0] : fixed_words.m;
         dco_words.s = (state == adpll_types_pkg::ST_CS && !accum_clr) ?
                       otw_sat[adpll_cfg_pkg::MSW-1:0] : fixed_words.s;
      end
   end

   assign channel_sat = (dco_words.s == adpll_cfg_pkg::MS_MIN) ||
                        (dco_words.s == adpll_cfg_pkg::MS_MAX);

endmodule

// File: design/adpll_ctrl.sv
module adpll_ctrl (
   input  logic                                clk,
   input  logic                                rst_accum_all,
   input  logic [adpll_cfg_pkg::FCWW-1:0]      fcw,
   input  adpll_types_pkg::adpll_mode_e        adpll_mode,
   input  logic [adpll_cfg_pkg::INTW-1:0]      tdc_word,
   input  adpll_types_pkg::coef_regs_s         coefs,
   input  adpll_types_pkg::test_ctrl_s         test,
   output adpll_types_pkg::bank_words_s        dco_words,
   output adpll_types_pkg::pwr_ctrl_s          pwr,
   output logic                                channel_lock,
   output logic                                channel_sat
);

   adpll_types_pkg::acq_state_e            state;
   adpll_types_pkg::filt_cfg_s             filt;
   adpll_types_pkg::bank_words_s           fixed_words;
   adpll_types_pkg::pwr_ctrl_s             pwr_seq;
   logic                                   accum_clr;
   logic                                   ld_en, ld_clr;
   logic                                   lock_seen;
   logic signed [adpll_cfg_pkg::OTWW-1:0]  lock_word;
   logic signed [adpll_cfg_pkg::OTWW-1:0]  otw_round, otw_sat;

   ///////////////////////////////////////////////////////////////////////
   // Loop filter and acquisition control
   ///////////////////////////////////////////////////////////////////////

   loop_filter loop_filter0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .accum_clr(accum_clr),
      .fcw(fcw), .tdc_word(tdc_word), .filt(filt), .otw_round(otw_round)
   );

   acq_sequencer acq_sequencer0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .fcw(fcw), .mode(adpll_mode),
      .coefs(coefs), .lock_seen(lock_seen), .lock_word(lock_word), .state(state),
      .filt(filt), .accum_clr(accum_clr), .ld_en(ld_en), .ld_clr(ld_clr),
      .fixed_words(fixed_words), .pwr(pwr_seq), .channel_lock(channel_lock)
   );

   freq_lock_detector freq_lock_detector0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .ld_en(ld_en), .ld_clr(ld_clr),
      .state(state), .otw_sat(otw_sat), .lock_seen(lock_seen), .lock_word(lock_word)
   );

   bank_word_combiner bank_word_combiner0 (
      .state(state), .mode(adpll_mode), .accum_clr(accum_clr), .otw_round(otw_round),
      .fixed_words(fixed_words), .test(test), .otw_sat(otw_sat),
      .dco_words(dco_words), .channel_sat(channel_sat)
   );

   // Test mode drives the analog power-downs directly
   assign pwr = (adpll_mode == adpll_types_pkg::MODE_TEST) ? test.pd : pwr_seq;

endmodule

// File: verification/adpll_ctrl_tb.sv
module adpll_ctrl_tb;

   logic                                 clk;
   logic                                 rst_accum_all;
   logic [adpll_cfg_pkg::FCWW-1:0]       fcw;
   adpll_types_pkg::adpll_mode_e         adpll_mode;
   logic [adpll_cfg_pkg::INTW-1:0]       tdc_word;
   adpll_types_pkg::coef_regs_s          coefs;
   adpll_types_pkg::test_ctrl_s          test;
   adpll_types_pkg::bank_words_s         dco_words;
   adpll_types_pkg::pwr_ctrl_s           pwr;
   logic                                 channel_lock;
   logic                                 channel_sat;
   logic [31:0]                          lfsr_state;

   typedef enum {W_IN_CS, W_LOCKED, W_UNLOCKED, W_SAT} wait_cond_e;

   adpll_ctrl dut0 (
      .clk(clk), .rst_accum_all(rst_accum_all), .fcw(fcw), .adpll_mode(adpll_mode),
      .tdc_word(tdc_word), .coefs(coefs), .test(test), .dco_words(dco_words),
      .pwr(pwr), .channel_lock(channel_lock), .channel_sat(channel_sat)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_eq(input string name, input int expected, input int actual);
      if (expected !== actual) begin
         abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   // Expected saturated word for the large or the medium/small bank
   function automatic int bank_clamp(input int value, input logic large_bank);
      int hi;
      int lo;
      hi = large_bank ? adpll_cfg_pkg::L_MAX : adpll_cfg_pkg::MS_MAX;
      lo = large_bank ? adpll_cfg_pkg::L_MIN : adpll_cfg_pkg::MS_MIN;
      if (value > hi) begin
         return hi;
      end else if (value < lo) begin
         return lo;
      end
      return value;
   endfunction

   function automatic logic cond_met(input wait_cond_e cond);
      case (cond)
         W_IN_CS:    return dut0.state == adpll_types_pkg::ST_CS;
         W_LOCKED:   return channel_lock;
         W_UNLOCKED: return !channel_lock;
         default:    return channel_sat;
      endcase
   endfunction

   task automatic wait_for(input wait_cond_e cond, input int limit, input string what,
                           output int cycles);
      cycles = 0;
      while (!cond_met(cond) && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!cond_met(cond)) begin
         abort_run({"Timed out waiting for ", what});
      end
   endtask

   // Random integer FCW, zero fraction, TDC word off by err
   task automatic pick_fcw(input int err);
      logic [31:0]                     r;
      logic [adpll_cfg_pkg::INTW-1:0]  fcw_int;
      draw_bits(10, r);
      fcw_int  = {2'b00, r[9:0]} + 12'd16;
      fcw      = {fcw_int, {adpll_cfg_pkg::FRAW{1'b0}}};
      tdc_word = fcw_int - err[adpll_cfg_pkg::INTW-1:0];
   endtask

   // Mode change seen after 2 edges, then each mark falls one edge after its count
   task automatic measure_power_up();
      int k;
      int t_dco;
      int t_tdc;
      int t_inj;
      int t_cl;
      k     = 0;
      t_dco = -1;
      t_tdc = -1;
      t_inj = -1;
      t_cl  = -1;
      while (t_cl < 0 && k < 200) begin
         @(negedge clk);
         k++;
         if (t_dco < 0 && !pwr.dco_pd)
            t_dco = k;
         if (t_tdc < 0 && !pwr.tdc_pd)
            t_tdc = k;
         if (t_inj < 0 && !pwr.tdc_pd_inj)
            t_inj = k;
         if (dut0.state == adpll_types_pkg::ST_CL)
            t_cl = k;
      end
      if (t_cl < 0) begin
         abort_run("Timed out waiting for large-bank acquisition after power-up");
      end
      check_eq("dco_pd_fall", 3, t_dco);
      check_eq("tdc_pd_fall", adpll_cfg_pkg::T_TDC_PU + 3, t_tdc);
      check_eq("tdc_pd_inj_fall", adpll_cfg_pkg::T_INJ_PU + 3, t_inj);
      check_eq("coarse_start", adpll_cfg_pkg::T_PU_DONE + 3, t_cl);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test-mode override checked every cycle, a quarter period after the edge
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin : compare_outputs
      int s_test;
      #25;
      s_test = int'($signed(test.words.s));
      if (!rst_accum_all && adpll_mode == adpll_types_pkg::MODE_TEST) begin
         check_eq("test_override_words", int'(test.words), int'(dco_words));
         check_eq("test_override_pwr", int'(test.pd), int'(pwr));
         check_eq("test_channel_sat", int'(s_test == adpll_cfg_pkg::MS_MIN ||
                  s_test == adpll_cfg_pkg::MS_MAX), int'(channel_sat));
      end
   end

   initial begin
      int          n;
      int          big;
      logic [31:0] r;
      clk           = 1'b0;
      rst_accum_all = 1'b1;
      adpll_mode    = adpll_types_pkg::MODE_PD;
      fcw           = '0;
      tdc_word      = '0;
      test          = '0;
      coefs.alpha_l    = 4'd4;
      coefs.alpha_m    = 4'd4;
      coefs.beta       = 4'd0;
      coefs.rx.alpha_s = 4'd4;
      coefs.rx.lambda  = 3'd2;
      coefs.rx.iir_n   = 2'd1;
      coefs.tx.alpha_s = 4'd5;
      coefs.tx.lambda  = 3'd1;
      coefs.tx.iir_n   = 2'd2;
      lfsr_state    = 32'h8a9;
      // Well past any bank limit
      big = 4095;
      repeat (16) @(negedge clk);
      rst_accum_all = 1'b0;

      // Power-down mode right after reset
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         check_eq("reset_pwr", int'(3'b111), int'(pwr));
         check_eq("reset_channel_lock", 0, int'(channel_lock));
         check_eq("reset_channel_sat", 0, int'(channel_sat));
         check_eq("reset_dco_words", 0, int'(dco_words));
      end

      // Test mode drives words and power-downs straight through
      adpll_mode = adpll_types_pkg::MODE_TEST;
      pick_fcw(0);
      for (int i = 0; i < 6; i++) begin
         draw_bits(24, r);
         test = r[23:0];
         @(negedge clk);
         check_eq("test_words", int'(test.words), int'(dco_words));
         check_eq("test_pwr", int'(test.pd), int'(pwr));
      end

      // Receive with zero phase error
      adpll_mode = adpll_types_pkg::MODE_RX;
      measure_power_up();
      wait_for(W_IN_CS, 300, "the small-bank state", n);
      wait_for(W_LOCKED, adpll_cfg_pkg::T_CH_LOCK + 20, "channel lock", n);
      check_eq("channel_lock_delay", adpll_cfg_pkg::T_CH_LOCK + 1, n);
      check_eq("zero_l_word", 0, int'($signed(dco_words.l)));
      check_eq("zero_m_word", 0, int'($signed(dco_words.m)));
      check_eq("zero_s_word", 0, int'($signed(dco_words.s)));
      check_eq("zero_channel_sat", 0, int'(channel_sat));

      // Constant positive error drives every bank to its upper limit
      pick_fcw(1);
      wait_for(W_UNLOCKED, 4, "channel lock to drop after an FCW change", n);
      wait_for(W_SAT, 600, "positive small-bank saturation", n);
      check_eq("pos_l_word", bank_clamp(big, 1'b1), int'($signed(dco_words.l)));
      check_eq("pos_m_word", bank_clamp(big, 1'b0), int'($signed(dco_words.m)));
      check_eq("pos_s_word", bank_clamp(big, 1'b0), int'($signed(dco_words.s)));
      wait_for(W_LOCKED, adpll_cfg_pkg::T_CH_LOCK + 100, "channel lock", n);

      // New FCW after lock restarts power-up, then negative error in transmit
      adpll_mode = adpll_types_pkg::MODE_TX;
      pick_fcw(-1);
      wait_for(W_UNLOCKED, 4, "channel lock to drop after an FCW change", n);
      check_eq("restart_l_word", 0, int'($signed(dco_words.l)));
      wait_for(W_SAT, 600, "negative small-bank saturation", n);
      check_eq("neg_l_word", bank_clamp(-big, 1'b1), int'($signed(dco_words.l)));
      check_eq("neg_m_word", bank_clamp(-big, 1'b0), int'($signed(dco_words.m)));
      check_eq("neg_s_word", bank_clamp(-big, 1'b0), int'($signed(dco_words.s)));

      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: adpll_ctrl.f
design/adpll_cfg_pkg.sv
design/adpll_types_pkg.sv
design/loop_filter.sv
design/acq_sequencer.sv
design/freq_lock_detector.sv
design/bank_word_combiner.sv
design/adpll_ctrl.sv
verification/adpll_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the adpll_ctrl testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module adpll_ctrl_tb -f adpll_ctrl.f -o adpll_ctrl_sim \
   && ./obj_dir/adpll_ctrl_sim \
   || { echo "simulation failed"; exit 1; }
